/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sha512
FILELIST   := sha512.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulation binary exits with a failing status on $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sha512.f */
sha512_pkg.sv
sha512_core_if.sv
sha512_msg_schedule.sv
sha512_core.sv
sha512_regs.sv
sha512.sv
tb_sha512.sv

/* sha512.sv */
// Top level of the SHA-512 accelerator, register block beside the core it steers
`timescale 1ns/1ns

module sha512
  import sha512_pkg::*;
#(
  parameter int addr_w = 8
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              debug_zeroize,
  input  logic              cs,
  input  logic              we,
  input  logic [addr_w-1:0] address,
  input  logic [bus_w-1:0]  write_data,
  output logic [bus_w-1:0]  read_data,
  output logic              err,
  output logic              notif_intr
);

  sha512_core_if core_if ();

  sha512_regs #(
    .addr_w (addr_w)
  ) regs_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .debug_zeroize (debug_zeroize),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .err           (err),
    .notif_intr    (notif_intr),
    .regs          (core_if.regs)
  );

  sha512_core core_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .core    (core_if.core)
  );

endmodule

/* sha512_core.sv */
// SHA-512 compression core, one round per cycle, driven through the core side of the bundle
`timescale 1ns/1ns

module sha512_core
  import sha512_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  sha512_core_if.core   core
);

  localparam int round_w = $clog2(num_rounds);

  typedef enum logic [1:0] {
    st_idle,
    st_rounds,
    st_final
  } state_t;

  state_t             state;
  logic [round_w-1:0] round;
  logic               ready_q;
  logic               valid_q;
  logic               accept;
  hash_state_t        hash_q;
  hash_state_t        work;
  hash_state_t        work_next;
  sha_word_t          w;
  sha_word_t          t1;
  sha_word_t          t2;

  function automatic sha_word_t big_sigma0(sha_word_t x);
    return ((x >> 28) | (x << 36)) ^ ((x >> 34) | (x << 30)) ^ ((x >> 39) | (x << 25));
  endfunction

  function automatic sha_word_t big_sigma1(sha_word_t x);
    return ((x >> 14) | (x << 50)) ^ ((x >> 18) | (x << 46)) ^ ((x >> 41) | (x << 23));
  endfunction

  // Busy commands are dropped, including the cycle right after acceptance
  assign accept = (core.init | core.next) & ready_q & (state == st_idle);

  sha512_msg_schedule msg_schedule_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (accept),
    .shift   (state == st_rounds),
    .block   (core.block),
    .w       (w)
  );

  // ------------------------------------------------------------
  // Round function on working variables a..h
  // ------------------------------------------------------------
  always_comb begin
    t1 = work[7] + big_sigma1(work[4]) + ((work[4] & work[5]) ^ (~work[4] & work[6]))
       + k_round[round] + w;
    t2 = big_sigma0(work[0]) + ((work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]));
    work_next = {t1 + t2, work[0], work[1], work[2], work[3] + t1, work[4], work[5], work[6]};
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      work <= '0;
    end else if (core.zeroize) begin
      work <= '0;
    end else if (accept) begin
      work <= core.init ? h_init : hash_q;
    end else if (state == st_rounds) begin
      work <= work_next;
    end
  end

  // ------------------------------------------------------------
  // Sequencing and chaining state
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= st_idle;
      round   <= '0;
      ready_q <= 1'b1;
      valid_q <= 1'b0;
      hash_q  <= '0;
    end else if (core.zeroize) begin
      state   <= st_idle;
      round   <= '0;
      ready_q <= 1'b1;
      valid_q <= 1'b0;
      hash_q  <= '0;
    end else begin
      // Ready follows the state one cycle late
      ready_q <= (state == st_idle);
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_rounds;
            round   <= '0;
            valid_q <= 1'b0;
            // Init restarts the chain from H(0)
            if (core.init) begin
              hash_q <= h_init;
            end
          end else if (!ready_q) begin
            // Last cycle of a run, digest already final
            valid_q <= 1'b1;
          end
        end
        st_rounds: begin
          if (round == round_w'(num_rounds - 1)) begin
            state <= st_final;
          end else begin
            round <= round + 1'b1;
          end
        end
        default: begin
          for (int i = 0; i < 8; i++) begin
            hash_q[i] <= hash_q[i] + work[i];
          end
          state <= st_idle;
        end
      endcase
    end
  end

  assign core.ready        = ready_q;
  assign core.digest_valid = valid_q;
  assign core.digest       = hash_q;

endmodule

/* sha512_core_if.sv */
// Bundle between register block and core carrying command strobes, block, status and digest
`timescale 1ns/1ns

interface sha512_core_if
  import sha512_pkg::*;
();

  // Command strobes, each high for one cycle
  logic        init;
  logic        next;
  logic        zeroize;
  msg_block_t  block;

  // Core status and chaining state
  logic        ready;
  logic        digest_valid;
  hash_state_t digest;

  modport regs (output init, next, zeroize, block, input ready, digest_valid, digest);
  modport core (input init, next, zeroize, block, output ready, digest_valid, digest);

endinterface

/* sha512_msg_schedule.sv */
// SHA-512 message schedule, loaded with a block and shifted once per round to supply W[t]
`timescale 1ns/1ns

module sha512_msg_schedule
  import sha512_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       load,
  input  logic       shift,
  input  msg_block_t block,
  output sha_word_t  w
);

  sha_word_t [0:15] window;
  sha_word_t        w_new;

  function automatic sha_word_t small_sigma0(sha_word_t x);
    return ((x >> 1) | (x << 63)) ^ ((x >> 8) | (x << 56)) ^ (x >> 7);
  endfunction

  function automatic sha_word_t small_sigma1(sha_word_t x);
    return ((x >> 19) | (x << 45)) ^ ((x >> 61) | (x << 3)) ^ (x >> 6);
  endfunction

  // W[t+16] from the current window W[t..t+15]
  assign w_new = small_sigma1(window[14]) + window[9] + small_sigma0(window[1]) + window[0];

  // Oldest word is the one used by the current round
  assign w = window[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      window <= '0;
    end else if (load) begin
      window <= block;
    end else if (shift) begin
      for (int i = 0; i < 15; i++) begin
        window[i] <= window[i+1];
      end
      window[15] <= w_new;
    end
  end

endmodule

/* sha512_pkg.sv */
// Shared SHA-512 widths, register map, control bits and hash constants for design and testbench
package sha512_pkg;

  // ------------------------------------------------------------
  // Widths and counts
  // ------------------------------------------------------------
  localparam int word_w       = 64;
  localparam int bus_w        = 32;
  localparam int block_words  = 32;
  localparam int digest_words = 16;
  localparam int num_rounds   = 80;

  typedef logic [word_w-1:0] sha_word_t;

  // Element 0 is H0 and sits in the most significant position
  typedef sha_word_t [0:7] hash_state_t;

  // Word 0 of the message block is the most significant
  typedef sha_word_t [0:15] msg_block_t;

  // ------------------------------------------------------------
  // Register word offsets
  // ------------------------------------------------------------
  localparam int unsigned reg_ctrl        = 32'h00;
  localparam int unsigned reg_status      = 32'h01;
  localparam int unsigned reg_block_base  = 32'h10;
  localparam int unsigned reg_digest_base = 32'h40;

  // Control register bits, all self clearing
  localparam int ctrl_init       = 0;
  localparam int ctrl_next       = 1;
  localparam int ctrl_zeroize    = 2;
  localparam int ctrl_intr_clear = 3;

  // Status register bits
  localparam int stat_ready = 0;
  localparam int stat_valid = 1;

  // ------------------------------------------------------------
  // Initial hash value, FIPS 180-4 section 5.3.5
  // ------------------------------------------------------------
  localparam hash_state_t h_init = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
    64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
    64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  // ------------------------------------------------------------
  // Round constants, one per round
  // ------------------------------------------------------------
  localparam sha_word_t [0:num_rounds-1] k_round = {
    64'h428a2f98d728ae22, 64'h7137449123ef65cd,
    64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019,
    64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe,
    64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1,
    64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3,
    64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483,
    64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210,
    64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725,
    64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926,
    64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8,
    64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001,
    64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910,
    64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53,
    64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb,
    64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60,
    64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9,
    64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207,
    64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6,
    64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493,
    64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a,
    64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

endpackage

/* sha512_regs.sv */
// Register block of the SHA-512 accelerator, decodes bus accesses and steers the core
`timescale 1ns/1ns

module sha512_regs
  import sha512_pkg::*;
#(
  parameter int addr_w = 8
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              debug_zeroize,
  input  logic              cs,
  input  logic              we,
  input  logic [addr_w-1:0] address,
  input  logic [bus_w-1:0]  write_data,
  output logic [bus_w-1:0]  read_data,
  output logic              err,
  output logic              notif_intr,
  sha512_core_if.regs       regs
);

  localparam int blk_idx_w = $clog2(block_words);
  localparam int dig_idx_w = $clog2(digest_words);

  logic [bus_w-1:0]     block_q [block_words];
  logic                 hit_ctrl;
  logic                 hit_status;
  logic                 hit_block;
  logic                 hit_digest;
  logic                 ctrl_wr;
  logic [blk_idx_w-1:0] blk_idx;
  logic [dig_idx_w-1:0] dig_idx;
  logic [bus_w-1:0]     rd_mux;
  logic                 valid_d;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  assign hit_ctrl   = (address == addr_w'(reg_ctrl));
  assign hit_status = (address == addr_w'(reg_status));
  assign hit_block  = (address >= addr_w'(reg_block_base)) &&
                      (address < addr_w'(reg_block_base + block_words));
  assign hit_digest = (address >= addr_w'(reg_digest_base)) &&
                      (address < addr_w'(reg_digest_base + digest_words));

  assign blk_idx = blk_idx_w'(address - addr_w'(reg_block_base));
  assign dig_idx = dig_idx_w'(address - addr_w'(reg_digest_base));

  assign ctrl_wr = cs & we & hit_ctrl;

  // Control bits act only in the write cycle, so they read back as zero
  assign regs.init    = ctrl_wr & write_data[ctrl_init];
  assign regs.next    = ctrl_wr & write_data[ctrl_next];
  assign regs.zeroize = (ctrl_wr & write_data[ctrl_zeroize]) | debug_zeroize;

  // Word 0 lands in the upper half of message word 0
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      regs.block[i] = {block_q[2*i], block_q[2*i+1]};
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < block_words; i++) begin
        block_q[i] <= '0;
      end
    end else if (regs.zeroize) begin
      for (int i = 0; i < block_words; i++) begin
        block_q[i] <= '0;
      end
    end else if (cs && we && hit_block) begin
      block_q[blk_idx] <= write_data;
    end
  end

  // ------------------------------------------------------------
  // Read path and error pulse
  // ------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    if (hit_status) begin
      rd_mux[stat_ready] = regs.ready;
      rd_mux[stat_valid] = regs.digest_valid;
    end else if (hit_block) begin
      rd_mux = block_q[blk_idx];
    end else if (hit_digest) begin
      // Even offsets return the upper half, big-endian order
      if (dig_idx[0]) begin
        rd_mux = regs.digest[dig_idx[dig_idx_w-1:1]][bus_w-1:0];
      end else begin
        rd_mux = regs.digest[dig_idx[dig_idx_w-1:1]][word_w-1:bus_w];
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_data <= '0;
      err       <= 1'b0;
    end else begin
      if (cs && !we) begin
        read_data <= rd_mux;
      end
      err <= cs & (~(hit_ctrl | hit_status | hit_block | hit_digest) |
                   (we & (hit_status | hit_digest)));
    end
  end

  // Sticky command-done interrupt
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_d    <= 1'b0;
      notif_intr <= 1'b0;
    end else begin
      valid_d <= regs.digest_valid;
      if (regs.zeroize) begin
        notif_intr <= 1'b0;
      end else if (regs.digest_valid && !valid_d) begin
        notif_intr <= 1'b1;
      end else if (ctrl_wr && write_data[ctrl_intr_clear]) begin
        notif_intr <= 1'b0;
      end
    end
  end

endmodule

/* tb_sha512.sv */
// Random-stimulus testbench for the SHA-512 accelerator, run as top with the file list
`timescale 1ns/1ns

module tb_sha512
  import sha512_pkg::*;
();

  localparam int addr_w = 8;

  // Standard SHA-512 digest of "abc"
  localparam hash_state_t abc_digest = {
    64'hddaf35a193617aba, 64'hcc417349ae204131,
    64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd,
    64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f
  };

  logic              clk;
  logic              reset_n;
  logic              debug_zeroize;
  logic              cs;
  logic              we;
  logic [addr_w-1:0] address;
  logic [bus_w-1:0]  write_data;
  logic [bus_w-1:0]  read_data;
  logic              err;
  logic              notif_intr;

  int unsigned cycle_cnt;
  int unsigned cmd_cycle;
  hash_state_t model_h;

  sha512 #(
    .addr_w (addr_w)
  ) sha512_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .debug_zeroize (debug_zeroize),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .err           (err),
    .notif_intr    (notif_intr)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic sha_word_t rotr(sha_word_t x, int n);
    return (x >> n) | (x << (word_w - n));
  endfunction

  function automatic hash_state_t compress_block(hash_state_t h, msg_block_t m);
    sha_word_t   w [num_rounds];
    sha_word_t   v [8];
    sha_word_t   s0;
    sha_word_t   s1;
    sha_word_t   ch;
    sha_word_t   maj;
    sha_word_t   tmp1;
    sha_word_t   tmp2;
    hash_state_t res;
    for (int t = 0; t < num_rounds; t++) begin
      if (t < 16) begin
        w[t] = m[t];
      end else begin
        s0 = rotr(w[t-15], 1) ^ rotr(w[t-15], 8) ^ (w[t-15] >> 7);
        s1 = rotr(w[t-2], 19) ^ rotr(w[t-2], 61) ^ (w[t-2] >> 6);
        w[t] = s1 + w[t-7] + s0 + w[t-16];
      end
    end
    for (int i = 0; i < 8; i++) begin
      v[i] = h[i];
    end
    for (int t = 0; t < num_rounds; t++) begin
      s1 = rotr(v[4], 14) ^ rotr(v[4], 18) ^ rotr(v[4], 41);
      ch = (v[4] & v[5]) ^ (~v[4] & v[6]);
      tmp1 = v[7] + s1 + ch + k_round[t] + w[t];
      s0 = rotr(v[0], 28) ^ rotr(v[0], 34) ^ rotr(v[0], 39);
      maj = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
      tmp2 = s0 + maj;
      for (int i = 7; i > 0; i--) begin
        v[i] = v[i-1];
      end
      v[4] = v[4] + tmp1;
      v[0] = tmp1 + tmp2;
    end
    for (int i = 0; i < 8; i++) begin
      res[i] = h[i] + v[i];
    end
    return res;
  endfunction

  function automatic msg_block_t random_block();
    msg_block_t m;
    for (int i = 0; i < 16; i++) begin
      m[i] = {$urandom, $urandom};
    end
    return m;
  endfunction

  // ------------------------------------------------------------
  // Failure reporting and checks
  // ------------------------------------------------------------
  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Bus tasks, called on a falling edge and returning on one
  // ------------------------------------------------------------
  task automatic bus_write(int unsigned offset, logic [31:0] data);
    cs = 1'b1;
    we = 1'b1;
    address = addr_w'(offset);
    write_data = data;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(int unsigned offset, output logic [31:0] data);
    cs = 1'b1;
    we = 1'b0;
    address = addr_w'(offset);
    @(posedge clk);
    @(negedge clk);
    cs = 1'b0;
    data = read_data;
  endtask

  task automatic write_block(msg_block_t m);
    for (int i = 0; i < 16; i++) begin
      bus_write(reg_block_base + 2 * i, m[i][63:32]);
      bus_write(reg_block_base + 2 * i + 1, m[i][31:0]);
    end
  endtask

  task automatic send_cmd(int bit_pos);
    bus_write(reg_ctrl, 32'(1) << bit_pos);
    cmd_cycle = cycle_cnt;
  endtask

  // Poll status until ready and valid, then check the command latency
  task automatic wait_done();
    logic [31:0] stat;
    int          polls;
    stat = '0;
    polls = 0;
    while (!(stat[stat_ready] && stat[stat_valid])) begin
      if (polls == 200) begin
        abort_run("timeout while waiting for the core to finish a hash");
      end else begin
        bus_read(reg_status, stat);
        polls++;
      end
    end
    check_equal("latency", 32'(cycle_cnt - cmd_cycle - 1), 32'd82);
  endtask

  task automatic check_digest(hash_state_t exp);
    logic [31:0] d;
    for (int j = 0; j < digest_words; j++) begin
      bus_read(reg_digest_base + j, d);
      check_equal($sformatf("digest word %0d", j), d,
                  (j % 2 == 1) ? exp[j/2][31:0] : exp[j/2][63:32]);
    end
  endtask

  task automatic hash_block(msg_block_t m, bit first);
    write_block(m);
    send_cmd(first ? ctrl_init : ctrl_next);
    model_h = compress_block(first ? h_init : model_h, m);
    wait_done();
    check_digest(model_h);
  endtask

  // One access, then err must pulse for exactly one cycle or stay low
  task automatic check_err(int unsigned offset, bit write, bit exp);
    logic [31:0] d;
    if (write) begin
      bus_write(offset, $urandom);
    end else begin
      bus_read(offset, d);
    end
    check_equal($sformatf("err after access to 0x%0h", offset), 32'(err), 32'(exp));
    @(negedge clk);
    check_equal("err one cycle later", 32'(err), 32'h0);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    msg_block_t  blk;
    logic [31:0] d;
    int          chain_len;

    clk = 1'b0;
    reset_n = 1'b0;
    debug_zeroize = 1'b0;
    cs = 1'b0;
    we = 1'b0;
    address = '0;
    write_data = '0;
    cycle_cnt = 0;
    cmd_cycle = 0;
    model_h = '0;
    void'($urandom(94));
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    bus_read(reg_status, d);
    check_equal("status after reset", d, 32'h1);
    bus_read(reg_ctrl, d);
    check_equal("ctrl after reset", d, 32'h0);
    check_equal("notif_intr after reset", 32'(notif_intr), 32'h0);
    check_digest('0);

    // Padded "abc" block
    blk = '0;
    blk[0] = 64'h6162638000000000;
    blk[15] = 64'h18;
    hash_block(blk, 1'b1);
    check_digest(abc_digest);
    bus_read(reg_status, d);
    check_equal("status after hash", d, 32'h3);

    repeat (20) begin
      hash_block(random_block(), 1'b1);
    end

    // Chains, each following block written while the core is busy
    repeat (4) begin
      chain_len = $urandom_range(4, 2);
      blk = random_block();
      write_block(blk);
      send_cmd(ctrl_init);
      model_h = compress_block(h_init, blk);
      for (int n = 1; n < chain_len; n++) begin
        blk = random_block();
        write_block(blk);
        wait_done();
        check_digest(model_h);
        send_cmd(ctrl_next);
        model_h = compress_block(model_h, blk);
      end
      wait_done();
      check_digest(model_h);
    end

    // Start from a cleared interrupt so the next completion must raise it
    bus_write(reg_ctrl, 32'(1) << ctrl_intr_clear);
    check_equal("notif_intr before run", 32'(notif_intr), 32'h0);

    // Second init while busy must be dropped
    blk = random_block();
    write_block(blk);
    send_cmd(ctrl_init);
    model_h = compress_block(h_init, blk);
    write_block(random_block());
    bus_write(reg_ctrl, 32'(1) << ctrl_init);
    check_equal("notif_intr while busy", 32'(notif_intr), 32'h0);
    wait_done();
    check_digest(model_h);

    // Interrupt stays set until cleared
    check_equal("notif_intr after done", 32'(notif_intr), 32'h1);
    repeat (3) @(negedge clk);
    check_equal("notif_intr held", 32'(notif_intr), 32'h1);
    bus_write(reg_ctrl, 32'(1) << ctrl_intr_clear);
    check_equal("notif_intr after clear", 32'(notif_intr), 32'h0);
    check_equal("err after ctrl write", 32'(err), 32'h0);

    check_err(reg_ctrl, 1'b0, 1'b0);
    check_err(reg_status, 1'b0, 1'b0);
    check_err(reg_block_base + 5, 1'b1, 1'b0);
    check_err(reg_digest_base + 3, 1'b0, 1'b0);
    check_err(32'h02, 1'b0, 1'b1);
    check_err(32'h30, 1'b0, 1'b1);
    check_err($urandom_range(255, 80), 1'b0, 1'b1);
    check_err(reg_status, 1'b1, 1'b1);
    check_err(reg_digest_base + $urandom_range(15, 0), 1'b1, 1'b1);

    // Zeroize during a run, through ctrl and then through debug_zeroize
    for (int z = 0; z < 2; z++) begin
      write_block(random_block());
      send_cmd(ctrl_init);
      repeat (20) @(negedge clk);
      if (z == 0) begin
        bus_write(reg_ctrl, 32'(1) << ctrl_zeroize);
      end else begin
        debug_zeroize = 1'b1;
        @(negedge clk);
        debug_zeroize = 1'b0;
      end
      bus_read(reg_status, d);
      check_equal("status after zeroize", d, 32'h1);
      check_digest('0);
      for (int i = 0; i < block_words; i++) begin
        bus_read(reg_block_base + i, d);
        check_equal($sformatf("block word %0d after zeroize", i), d, 32'h0);
      end
      repeat (40) @(negedge clk);
      bus_read(reg_status, d);
      check_equal("status long after zeroize", d, 32'h1);
      hash_block(random_block(), 1'b1);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule
